//--- hw/keypad_pkg.sv
// Keypad geometry and scan timing constants
// Key code, column, row and key event types
// Scanner state encoding
package keypad_pkg;

    // Matrix size
    localparam int NUM_COLS = 4;
    localparam int NUM_ROWS = 4;

    // Clock cycles per column window
    localparam int SCAN_DWELL = 8;
    // Full scans that must agree before a key state is taken
    localparam int DEBOUNCE_SCANS = 3;
    // Event buffer entries
    localparam int EVENT_FIFO_DEPTH = 4;

    // Column times 4 plus row
    typedef logic [3:0] key_code_t;
    typedef logic [1:0] col_idx_t;
    typedef logic [1:0] row_idx_t;

    // Counters inside the scanner
    typedef logic [$clog2(SCAN_DWELL)-1:0]       dwell_cnt_t;
    typedef logic [$clog2(DEBOUNCE_SCANS+1)-1:0] deb_cnt_t;

    // One key event, release bit above the code
    typedef struct packed {
        logic      is_release;
        key_code_t code;
    } key_event_t;

    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_DRIVE,
        SCAN_SAMPLE
    } scan_state_t;

endpackage

//--- hw/wb_log_pkg.sv
// Wishbone bus widths for the log writer
// Log placement in external memory
// Sequence number type and writer state encoding
package wb_log_pkg;

    // Bus fields
    typedef logic [31:0] wb_addr_t;
    typedef logic [31:0] wb_data_t;
    typedef logic [3:0]  wb_sel_t;

    // Running event count stored in each record
    typedef logic [15:0] seq_t;

    // Byte address of log word 0
    localparam logic [31:0] LOG_BASE = 32'h0000_1000;
    // Words before the log wraps
    localparam int LOG_DEPTH = 8;

    typedef logic [$clog2(LOG_DEPTH)-1:0] log_idx_t;

    // Writer FSM
    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_WRITE,
        BUS_GAP
    } bus_state_t;

endpackage

//--- hw/key_event_if.sv
// Valid/ready channel for key events
// Source and sink modports
`timescale 1ns/1ps

interface key_event_if (
    input logic clk
);

    // Handshake, transfer when both high on a rising edge
    logic valid;
    logic ready;
    // Event payload, held while valid and not yet taken
    keypad_pkg::key_event_t data;

    // Producer side
    modport source (
        input  clk,
        input  ready,
        output valid,
        output data
    );

    // Consumer side
    modport sink (
        input  clk,
        input  valid,
        input  data,
        output ready
    );

endinterface

//--- hw/keypad_scanner.sv
// Matrix keypad column scanner
// Row synchronizer, per-scan lowest key search and scan debouncer
// Release and press event generation on a valid/ready source
`timescale 1ns/1ps

module keypad_scanner (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            en,
    input  logic [keypad_pkg::NUM_ROWS-1:0] read_row,
    output logic [keypad_pkg::NUM_COLS-1:0] scan_col,
    key_event_if.source                     evt
);

    // Scan sequencing
    keypad_pkg::scan_state_t state;
    keypad_pkg::col_idx_t    col;
    keypad_pkg::dwell_cnt_t  dwell;

    // Rows come from pins, two flops
    logic [keypad_pkg::NUM_ROWS-1:0] row_meta;
    logic [keypad_pkg::NUM_ROWS-1:0] row_sync;

    // Result of the scan in progress
    logic                  scan_hit;
    keypad_pkg::key_code_t scan_code;
    logic                  hit_next;
    keypad_pkg::key_code_t code_next;
    keypad_pkg::row_idx_t  row_lo;
    logic                  scan_done;

    // Debounce candidate and accepted key state
    logic                  cand_hit;
    keypad_pkg::key_code_t cand_code;
    keypad_pkg::deb_cnt_t  deb_cnt;
    logic                  acc_hit;
    keypad_pkg::key_code_t acc_code;
    logic                  stable;

    // Events still owed to the sink
    logic                  pend_rel;
    logic                  pend_press;
    keypad_pkg::key_code_t rel_code;
    keypad_pkg::key_code_t press_code;

    always_ff @(posedge clk) begin
        row_meta <= read_row;
        row_sync <= row_meta;
    end

    // One-hot column drive, all low when idle
    always_comb begin
        scan_col = '0;
        if (state != keypad_pkg::SCAN_IDLE) begin
            scan_col[col] = 1'b1;
        end
    end

    // Lowest pressed row in the current column
    always_comb begin
        row_lo = '0;
        for (int r = keypad_pkg::NUM_ROWS - 1; r >= 0; r--) begin
            if (row_sync[r]) begin
                row_lo = keypad_pkg::row_idx_t'(r);
            end
        end
    end

    // Earlier columns hold lower codes, so first hit wins
    assign hit_next  = scan_hit | (|row_sync);
    assign code_next = scan_hit ? scan_code :
                       ((|row_sync) ? keypad_pkg::key_code_t'({col, row_lo}) : '0);
    assign scan_done = (state == keypad_pkg::SCAN_SAMPLE) && en &&
                       (col == keypad_pkg::col_idx_t'(keypad_pkg::NUM_COLS - 1));

    // Column and dwell sequencing
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= keypad_pkg::SCAN_IDLE;
            col       <= '0;
            dwell     <= '0;
            scan_hit  <= 1'b0;
            scan_code <= '0;
        end else begin
            case (state)
                keypad_pkg::SCAN_IDLE: begin
                    col      <= '0;
                    dwell    <= '0;
                    scan_hit <= 1'b0;
                    if (en) begin
                        state <= keypad_pkg::SCAN_DRIVE;
                    end
                end
                keypad_pkg::SCAN_DRIVE: begin
                    if (!en) begin
                        state <= keypad_pkg::SCAN_IDLE;
                    end else begin
                        dwell <= dwell + 1'b1;
                        // Last cycle of the window is the sample
                        if (dwell == keypad_pkg::dwell_cnt_t'(keypad_pkg::SCAN_DWELL - 2)) begin
                            state <= keypad_pkg::SCAN_SAMPLE;
                        end
                    end
                end
                keypad_pkg::SCAN_SAMPLE: begin
                    dwell <= '0;
                    if (!en) begin
                        state <= keypad_pkg::SCAN_IDLE;
                    end else begin
                        state <= keypad_pkg::SCAN_DRIVE;
                        col   <= col + 1'b1;
                        if (scan_done) begin
                            // New scan starts empty
                            scan_hit  <= 1'b0;
                            scan_code <= '0;
                        end else begin
                            scan_hit  <= hit_next;
                            scan_code <= code_next;
                        end
                    end
                end
                default: state <= keypad_pkg::SCAN_IDLE;
            endcase
        end
    end

    assign stable = (deb_cnt == keypad_pkg::deb_cnt_t'(keypad_pkg::DEBOUNCE_SCANS));

    // Debounce, acceptance and event hand-off
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cand_hit   <= 1'b0;
            cand_code  <= '0;
            deb_cnt    <= '0;
            acc_hit    <= 1'b0;
            acc_code   <= '0;
            pend_rel   <= 1'b0;
            pend_press <= 1'b0;
        end else begin
            if (scan_done) begin
                if ({hit_next, code_next} != {cand_hit, cand_code}) begin
                    cand_hit  <= hit_next;
                    cand_code <= code_next;
                    deb_cnt   <= keypad_pkg::deb_cnt_t'(1);
                end else if (!stable) begin
                    deb_cnt <= deb_cnt + 1'b1;
                end
            end
            // Take a new state only once the last events are gone
            if (stable && !evt.valid && ({cand_hit, cand_code} != {acc_hit, acc_code})) begin
                acc_hit    <= cand_hit;
                acc_code   <= cand_code;
                pend_rel   <= acc_hit;
                rel_code   <= acc_code;
                pend_press <= cand_hit;
                press_code <= cand_code;
            end
            // Release goes out before press
            if (evt.valid && evt.ready) begin
                if (pend_rel) begin
                    pend_rel <= 1'b0;
                end else begin
                    pend_press <= 1'b0;
                end
            end
        end
    end

    assign evt.valid           = pend_rel | pend_press;
    assign evt.data.is_release = pend_rel;
    assign evt.data.code       = pend_rel ? rel_code : press_code;

endmodule

//--- hw/key_event_fifo.sv
// Show-ahead key event FIFO
// Circular buffer with read and write pointers and an entry count
// Sticky overflow flag for events dropped when full
`timescale 1ns/1ps

module key_event_fifo #(
    parameter int DEPTH = keypad_pkg::EVENT_FIFO_DEPTH
) (
    input  logic      clk,
    input  logic      rst_n,
    key_event_if.sink push_side,
    key_event_if.source pop_side,
    output logic      overflow
);

    typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(DEPTH+1)-1:0] count_t;

    keypad_pkg::key_event_t mem [DEPTH];
    ptr_t   wr_ptr;
    ptr_t   rd_ptr;
    count_t count;

    logic full;
    logic do_pop;
    logic do_push;

    assign full   = (count == count_t'(DEPTH));
    assign do_pop = pop_side.valid && pop_side.ready;
    // A pop on the same edge frees the slot
    assign do_push = push_side.valid && (!full || do_pop);

    // Never stalls the scanner
    assign push_side.ready = 1'b1;

    // Head is visible whenever something is stored
    assign pop_side.valid = (count != '0);
    assign pop_side.data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_side.data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Dropped event, held until reset
            if (push_side.valid && !do_push) begin
                overflow <= 1'b1;
            end
        end
    end

endmodule

//--- hw/wb_log_writer.sv
// Key event to log record formatter
// Wishbone classic single-write manager into a circular log
// Sequence number and log index tracking
`timescale 1ns/1ps

module wb_log_writer (
    input  logic                 clk,
    input  logic                 rst_n,
    key_event_if.sink            evt,
    output wb_log_pkg::wb_addr_t wb_adr,
    output wb_log_pkg::wb_data_t wb_dat_w,
    output wb_log_pkg::wb_sel_t  wb_sel,
    output logic                 wb_we,
    output logic                 wb_cyc,
    output logic                 wb_stb,
    input  logic                 wb_ack
);

    wb_log_pkg::bus_state_t state;
    wb_log_pkg::seq_t       seq;
    wb_log_pkg::log_idx_t   log_idx;

    wb_log_pkg::wb_data_t record;
    wb_log_pkg::wb_addr_t slot_adr;

    // Only take an event with the bus free
    assign evt.ready = (state == wb_log_pkg::BUS_IDLE);

    // Full words only
    assign wb_sel = '1;

    // Seq on top, release at bit 8, code in the low nibble
    assign record = {seq, 7'b0, evt.data.is_release, 4'b0, evt.data.code};

    // Word address of the current log slot
    assign slot_adr = wb_log_pkg::LOG_BASE + wb_log_pkg::wb_addr_t'({log_idx, 2'b00});

    // Address and data stay put from accept to ack
    always_ff @(posedge clk) begin
        if (evt.valid && evt.ready) begin
            wb_adr   <= slot_adr;
            wb_dat_w <= record;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= wb_log_pkg::BUS_IDLE;
            seq     <= '0;
            log_idx <= '0;
            wb_cyc  <= 1'b0;
            wb_stb  <= 1'b0;
            wb_we   <= 1'b0;
        end else begin
            case (state)
                wb_log_pkg::BUS_IDLE: begin
                    if (evt.valid) begin
                        // Cycle opens on the next clock
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        wb_we  <= 1'b1;
                        state  <= wb_log_pkg::BUS_WRITE;
                    end
                end
                wb_log_pkg::BUS_WRITE: begin
                    // Slow ack just waits here
                    if (wb_ack) begin
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        wb_we  <= 1'b0;
                        seq    <= seq + 1'b1;
                        if (log_idx == wb_log_pkg::log_idx_t'(wb_log_pkg::LOG_DEPTH - 1)) begin
                            log_idx <= '0;
                        end else begin
                            log_idx <= log_idx + 1'b1;
                        end
                        state <= wb_log_pkg::BUS_GAP;
                    end
                end
                wb_log_pkg::BUS_GAP: begin
                    // One idle cycle between writes
                    state <= wb_log_pkg::BUS_IDLE;
                end
                default: begin
                    state  <= wb_log_pkg::BUS_IDLE;
                    wb_cyc <= 1'b0;
                    wb_stb <= 1'b0;
                    wb_we  <= 1'b0;
                end
            endcase
        end
    end

endmodule

//--- hw/keypad_logger_top.sv
// Keypad event logger top level
// Scanner, event FIFO and Wishbone log writer on plain pins and bus ports
`timescale 1ns/1ps

module keypad_logger_top (
    input  logic                            clk,
    input  logic                            rst_n,
    // Stops scanning when low
    input  logic                            en,
    // Keypad pins
    input  logic [keypad_pkg::NUM_ROWS-1:0] read_row,
    output logic [keypad_pkg::NUM_COLS-1:0] scan_col,
    // Wishbone manager, write only
    output wb_log_pkg::wb_addr_t            wb_adr,
    output wb_log_pkg::wb_data_t            wb_dat_w,
    output wb_log_pkg::wb_sel_t             wb_sel,
    output logic                            wb_we,
    output logic                            wb_cyc,
    output logic                            wb_stb,
    input  logic                            wb_ack,
    // Events lost to a full FIFO
    output logic                            overflow
);

    // Scanner to FIFO
    key_event_if scan_if (.clk(clk));
    // FIFO to bus writer
    key_event_if log_if (.clk(clk));

    keypad_scanner u_scanner (
        .clk      (clk),
        .rst_n    (rst_n),
        .en       (en),
        .read_row (read_row),
        .scan_col (scan_col),
        .evt      (scan_if.source)
    );

    key_event_fifo #(
        .DEPTH (keypad_pkg::EVENT_FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push_side (scan_if.sink),
        .pop_side  (log_if.source),
        .overflow  (overflow)
    );

    wb_log_writer u_writer (
        .clk      (clk),
        .rst_n    (rst_n),
        .evt      (log_if.sink),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_we    (wb_we),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_ack   (wb_ack)
    );

endmodule

//--- tb/tb_clock_gen.sv
// Free-running testbench clock, 50 percent duty
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

//--- tb/keypad_logger_assertions.sv
// Bound protocol checks for the keypad logger
// Wishbone write handshake, bus state in reset, one-hot column drive
`timescale 1ns/1ps

module keypad_logger_assertions (
    input logic                            clk,
    input logic                            rst_n,
    input logic [keypad_pkg::NUM_COLS-1:0] scan_col,
    input wb_log_pkg::wb_addr_t            wb_adr,
    input wb_log_pkg::wb_data_t            wb_dat_w,
    input logic                            wb_cyc,
    input logic                            wb_stb,
    input logic                            wb_ack
);

    // Count of failed checks
    int fail_count = 0;

    // Strobe only inside a cycle
    stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n) wb_stb |-> wb_cyc)
        else begin
            fail_count++;
            $error("wb_stb high without wb_cyc");
        end

    // Address and data held until the memory acks
    adr_dat_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_dat_w)))
        else begin
            fail_count++;
            $error("wb_adr or wb_dat_w changed before ack");
        end

    // No bus cycle while reset is applied
    cyc_low_in_reset: assert property (@(posedge clk) !rst_n |=> !wb_cyc)
        else begin
            fail_count++;
            $error("wb_cyc high during reset");
        end

    // At most one column driven
    col_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(scan_col))
        else begin
            fail_count++;
            $error("more than one scan column driven");
        end

endmodule

bind keypad_logger_top keypad_logger_assertions u_assertions (
    .clk      (clk),
    .rst_n    (rst_n),
    .scan_col (scan_col),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_ack   (wb_ack)
);

//--- tb/keypad_logger_tb.sv
// Testbench for the keypad event logger
// Keypad and Wishbone memory models, directed tests, watchdog and summary
`timescale 1ns/1ps

module keypad_logger_tb;

    localparam int CLK_PERIOD  = 20;
    // One pass over all columns
    localparam int SCAN_CYCLES = keypad_pkg::NUM_COLS * keypad_pkg::SCAN_DWELL;
    // Worst case from a key change to its write, with margin
    localparam int EVENT_CYCLES = (keypad_pkg::DEBOUNCE_SCANS + 3) * SCAN_CYCLES;
    // Key changes over all tests plus slack for gaps and settling
    localparam int TOTAL_EVENTS = 2 + 20 + 8 + 6 + 8 + 16;
    localparam int WATCHDOG_CYCLES = TOTAL_EVENTS * 2 * EVENT_CYCLES;

    logic                            clk;
    logic                            rst_n = 1'b0;
    logic                            en = 1'b0;
    logic [keypad_pkg::NUM_ROWS-1:0] read_row = '0;
    logic [keypad_pkg::NUM_COLS-1:0] scan_col;
    wb_log_pkg::wb_addr_t            wb_adr;
    wb_log_pkg::wb_data_t            wb_dat_w;
    wb_log_pkg::wb_sel_t             wb_sel;
    logic                            wb_we;
    logic                            wb_cyc;
    logic                            wb_stb;
    logic                            wb_ack = 1'b0;
    logic                            overflow;

    // Held key of the keypad model
    logic                  key_down = 1'b0;
    keypad_pkg::key_code_t key_code = '0;

    // Memory model controls and captured writes
    logic ack_hold = 1'b0;
    int   ack_delay_max = 0;
    int   cur_delay = 0;
    int   wait_cnt = 0;
    int   write_count = 0;
    wb_log_pkg::wb_addr_t got_adr[$];
    wb_log_pkg::wb_data_t got_dat[$];

    // Log the DUT should have written
    wb_log_pkg::wb_addr_t exp_adr[$];
    wb_log_pkg::wb_data_t exp_dat[$];
    wb_log_pkg::seq_t     exp_seq = '0;
    int                   exp_idx = 0;

    int mismatch_errors = 0;
    int other_errors = 0;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD)) u_clk (.clk(clk));

    keypad_logger_top UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .en       (en),
        .read_row (read_row),
        .scan_col (scan_col),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_we    (wb_we),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_ack   (wb_ack),
        .overflow (overflow)
    );

    // Pressed key shorts its row to its column
    always @(posedge clk) begin
        read_row <= '0;
        if (key_down && scan_col[key_code[3:2]]) begin
            read_row[key_code[1:0]] <= 1'b1;
        end
    end

    // Memory: ack after cur_delay cycles, capture on the acked edge
    always @(posedge clk) begin
        if (wb_cyc && wb_stb && wb_ack) begin
            assert (wb_we && wb_sel == 4'hf) else begin
                mismatch_errors++;
                $display("Mismatch at %0t: write with we %b sel %h", $time, wb_we, wb_sel);
            end
            got_adr.push_back(wb_adr);
            got_dat.push_back(wb_dat_w);
            write_count++;
            wb_ack    <= 1'b0;
            wait_cnt  <= 0;
            cur_delay <= $urandom_range(ack_delay_max, 0);
        end else if (wb_cyc && wb_stb && !ack_hold) begin
            if (wait_cnt >= cur_delay) begin
                wb_ack <= 1'b1;
            end else begin
                wait_cnt <= wait_cnt + 1;
            end
        end else begin
            wb_ack <= 1'b0;
        end
    end

    // Expected log word and address for one event
    task automatic expect_event(input logic rel, input keypad_pkg::key_code_t code);
        wb_log_pkg::wb_data_t word;
        word        = '0;
        word[31:16] = exp_seq;
        word[8]     = rel;
        word[3:0]   = code;
        exp_dat.push_back(word);
        exp_adr.push_back(wb_log_pkg::LOG_BASE + 32'(4 * exp_idx));
        exp_seq++;
        exp_idx = (exp_idx + 1) % wb_log_pkg::LOG_DEPTH;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic set_key(input logic down, input keypad_pkg::key_code_t code);
        @(posedge clk);
        key_down <= down;
        key_code <= code;
    endtask

    // Block until a column starts a new drive window
    task automatic wait_column(input keypad_pkg::col_idx_t c);
        @(negedge clk);
        while (scan_col[c]) begin
            @(negedge clk);
        end
        while (!scan_col[c]) begin
            @(negedge clk);
        end
    endtask

    task automatic wait_writes(input int target);
        int cycles;
        cycles = 0;
        while (write_count < target && cycles < EVENT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        assert (write_count >= target) else begin
            other_errors++;
            $display("Error at %0t: log write %0d never arrived", $time, target);
        end
    endtask

    // Press, wait for its write, release, wait again
    task automatic tap_key(input keypad_pkg::key_code_t code);
        expect_event(1'b0, code);
        set_key(1'b1, code);
        wait_writes(write_count + 1);
        expect_event(1'b1, code);
        set_key(1'b0, code);
        wait_writes(write_count + 1);
    endtask

    task automatic compare_log(input string name);
        int n;
        assert (got_dat.size() == exp_dat.size()) else begin
            other_errors++;
            $display("Error at %0t: %s produced %0d log writes instead of %0d",
                     $time, name, got_dat.size(), exp_dat.size());
        end
        n = (got_dat.size() < exp_dat.size()) ? got_dat.size() : exp_dat.size();
        for (int i = 0; i < n; i++) begin
            assert (got_adr[i] == exp_adr[i] && got_dat[i] == exp_dat[i]) else begin
                mismatch_errors++;
                $display("Mismatch at %0t: %s write %0d got %h at %h, expected %h at %h",
                         $time, name, i, got_dat[i], got_adr[i], exp_dat[i], exp_adr[i]);
            end
        end
        got_adr.delete();
        got_dat.delete();
        exp_adr.delete();
        exp_dat.delete();
    endtask

    task automatic test_reset();
        repeat (10) begin
            @(posedge clk);
            rst_n <= 1'b0;
            @(negedge clk);
            assert (!wb_cyc && !wb_stb && !overflow) else begin
                mismatch_errors++;
                $display("Mismatch at %0t: bus or overflow active in reset", $time);
            end
        end
        @(posedge clk);
        rst_n <= 1'b1;
        en    <= 1'b1;
        // No key down, so the bus must stay quiet
        repeat (2 * SCAN_CYCLES) begin
            @(negedge clk);
            assert (!wb_cyc && !wb_stb && !overflow && write_count == 0) else begin
                mismatch_errors++;
                $display("Mismatch at %0t: activity with no key pressed", $time);
            end
        end
    endtask

    task automatic test_single_key();
        tap_key(4'h9);
        idle_cycles(SCAN_CYCLES);
        compare_log("single key");
    endtask

    task automatic test_random_keys(input int count, input string name);
        keypad_pkg::key_code_t code;
        repeat (count) begin
            code = keypad_pkg::key_code_t'($urandom_range(15, 0));
            tap_key(code);
            idle_cycles($urandom_range(20, 1));
        end
        compare_log(name);
    endtask

    task automatic test_enable_glitch();
        int start;
        start = write_count;
        @(posedge clk);
        en <= 1'b0;
        set_key(1'b1, 4'h3);
        repeat (EVENT_CYCLES) begin
            @(negedge clk);
            assert (scan_col == '0) else begin
                mismatch_errors++;
                $display("Mismatch at %0t: column %b driven while disabled", $time, scan_col);
            end
        end
        set_key(1'b0, 4'h3);
        idle_cycles(SCAN_CYCLES);
        @(posedge clk);
        en <= 1'b1;
        idle_cycles(EVENT_CYCLES);
        // Press far shorter than one scan
        // Starts with column 3 so exactly one sample sees it
        wait_column(2'd3);
        set_key(1'b1, 4'hc);
        idle_cycles(keypad_pkg::SCAN_DWELL + 2);
        set_key(1'b0, 4'hc);
        idle_cycles(EVENT_CYCLES);
        @(negedge clk);
        assert (write_count == start && !wb_cyc) else begin
            mismatch_errors++;
            $display("Mismatch at %0t: %0d writes from disabled or glitch keys",
                     $time, write_count - start);
        end
    endtask

    task automatic test_overflow();
        keypad_pkg::key_code_t code;
        int start;
        start = write_count;
        code = '0;
        ack_hold = 1'b1;
        // Writer holds one event, FIFO the next DEPTH, the rest are lost
        for (int i = 0; i < 8; i++) begin
            if (i % 2 == 0) begin
                code = keypad_pkg::key_code_t'($urandom_range(15, 0));
            end
            if (i < keypad_pkg::EVENT_FIFO_DEPTH + 1) begin
                expect_event(i % 2 == 1, code);
            end
            set_key(i % 2 == 0, code);
            idle_cycles(EVENT_CYCLES);
        end
        @(negedge clk);
        assert (overflow && wb_cyc && write_count == start) else begin
            mismatch_errors++;
            $display("Mismatch at %0t: overflow %b cyc %b with ack withheld",
                     $time, overflow, wb_cyc);
        end
        ack_hold = 1'b0;
        wait_writes(start + keypad_pkg::EVENT_FIFO_DEPTH + 1);
        idle_cycles(EVENT_CYCLES);
        @(negedge clk);
        assert (overflow) else begin
            mismatch_errors++;
            $display("Mismatch at %0t: overflow cleared without reset", $time);
        end
        compare_log("overflow");
    endtask

    initial begin
        void'($urandom(32'heaf7e866));
        test_reset();
        test_single_key();
        test_random_keys(10, "random keys");
        ack_delay_max = 5;
        test_random_keys(4, "slow memory");
        ack_delay_max = 0;
        test_enable_glitch();
        test_overflow();
        $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatch_errors, other_errors, UUT.u_assertions.fail_count);
        if (mismatch_errors == 0 && other_errors == 0 &&
            UUT.u_assertions.fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Watchdog sized from the worst case of every key change
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Error: watchdog expired after %0d cycles, tests did not finish",
                 WATCHDOG_CYCLES);
        $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatch_errors, other_errors + 1, UUT.u_assertions.fail_count);
        $display("Verification failed");
        $finish;
    end

endmodule

//--- sources.f
hw/keypad_pkg.sv
hw/wb_log_pkg.sv
hw/key_event_if.sv
hw/keypad_scanner.sv
hw/key_event_fifo.sv
hw/wb_log_writer.sv
hw/keypad_logger_top.sv
tb/tb_clock_gen.sv
tb/keypad_logger_assertions.sv
tb/keypad_logger_tb.sv
